// File: logic/issue_pkg.sv
/*
 * shared definitions for the two-wide issue stage
 * lane and data widths, unit budgets, RV32 opcodes,
 * vector typedefs and the decode enums
 */
`default_nettype none

package issue_pkg;

	localparam int N_WAY = 2;
	localparam int XLEN = 32;
	localparam int N_PHYS_REGS = 64;
	localparam int TAG_W = $clog2(N_PHYS_REGS);

	typedef logic [XLEN-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [31:0] inst_t;
	// holds 0 .. N_WAY
	typedef logic [$clog2(N_WAY+1)-1:0] lane_count_t;

	localparam tag_t ZERO_TAG = '0;

	// per-cycle issue budget of each unit class
	localparam lane_count_t ALU_UNITS = 2;
	localparam lane_count_t MULT_UNITS = 1;
	localparam lane_count_t LOAD_UNITS = 1;
	localparam lane_count_t STORE_UNITS = 1;
	localparam lane_count_t BRANCH_UNITS = 1;

	///////////////////////////////////////////////////////////////////////
	// RV32 major opcodes
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	///////////////////////////////////////////////////////////////////////
	// decode results, first member of each is the all-zero value
	typedef enum logic [2:0] {ALU, MULT, LOAD, STORE, BRANCH} unit_e;

	typedef enum logic [3:0] {
		ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA,
		MUL, MULH, MULHSU, MULHU
	} alu_func_e;

	typedef enum logic [1:0] {RS1, PC, ZERO} opa_sel_e;

	typedef enum logic [2:0] {RS2, I_IMM, S_IMM, B_IMM, U_IMM, J_IMM} opb_sel_e;

endpackage

`default_nettype wire

// File: logic/issue_decoder.sv
/*
 * per-lane instruction decoder
 * maps opcode, funct3 and funct7 to the ALU function,
 * operand selects, destination flag and unit class
 */
`timescale 1ns/1ps
`default_nettype none

module issue_decoder (
	input issue_pkg::inst_t [issue_pkg::N_WAY-1:0] inst,
	input logic [issue_pkg::N_WAY-1:0] lane_valid,
	output issue_pkg::alu_func_e [issue_pkg::N_WAY-1:0] alu_func,
	output issue_pkg::opa_sel_e [issue_pkg::N_WAY-1:0] opa_select,
	output issue_pkg::opb_sel_e [issue_pkg::N_WAY-1:0] opb_select,
	output logic [issue_pkg::N_WAY-1:0] has_dest,
	output issue_pkg::unit_e [issue_pkg::N_WAY-1:0] unit
);
	import issue_pkg::*;

	// funct3 table shared by OP_IMM and OP_REG
	// alt is instruction bit 30, sub only exists for register ops
	function automatic alu_func_e base_func(input logic [2:0] funct3, input logic alt,
		input logic reg_op);
		case (funct3)
			3'b000: base_func = (reg_op && alt) ? SUB : ADD;
			3'b001: base_func = SLL;
			3'b010: base_func = SLT;
			3'b011: base_func = SLTU;
			3'b100: base_func = XOR;
			3'b101: base_func = alt ? SRA : SRL;
			3'b110: base_func = OR;
			default: base_func = AND;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < N_WAY; i++) begin
			// defaults give an add with no destination
			alu_func[i] = ADD;
			opa_select[i] = RS1;
			opb_select[i] = RS2;
			has_dest[i] = 1'b0;
			unit[i] = ALU;
			if (lane_valid[i]) begin
				case (inst[i][6:0])
					OP_LUI: begin
						has_dest[i] = 1'b1;
						opa_select[i] = ZERO;
						opb_select[i] = U_IMM;
					end
					OP_AUIPC: begin
						has_dest[i] = 1'b1;
						opa_select[i] = PC;
						opb_select[i] = U_IMM;
					end
					OP_JAL: begin
						has_dest[i] = 1'b1;
						opa_select[i] = PC;
						opb_select[i] = J_IMM;
					end
					OP_JALR: begin
						has_dest[i] = 1'b1;
						opb_select[i] = I_IMM;
					end
					OP_BRANCH: begin
						opa_select[i] = PC;
						opb_select[i] = B_IMM;
						unit[i] = BRANCH;
					end
					OP_LOAD: begin
						has_dest[i] = 1'b1;
						opb_select[i] = I_IMM;
						unit[i] = LOAD;
					end
					OP_STORE: begin
						opb_select[i] = S_IMM;
						unit[i] = STORE;
					end
					OP_IMM: begin
						has_dest[i] = 1'b1;
						opb_select[i] = I_IMM;
						alu_func[i] = base_func(inst[i][14:12], inst[i][30], 1'b0);
					end
					OP_REG: begin
						has_dest[i] = 1'b1;
						if (inst[i][31:25] == FUNCT7_MULDIV) begin
							unit[i] = MULT;
							// low funct3 bits pick the multiply flavour
							case (inst[i][13:12])
								2'b00: alu_func[i] = MUL;
								2'b01: alu_func[i] = MULH;
								2'b10: alu_func[i] = MULHSU;
								default: alu_func[i] = MULHU;
							endcase
						end else begin
							alu_func[i] = base_func(inst[i][14:12], inst[i][30], 1'b1);
						end
					end
					default: begin
						// unknown opcode, keep the defaults
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/phys_regfile.sv
/*
 * physical register file
 * two write ports, four combinational read ports,
 * reads of the current x0 register return zero
 */
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
	input logic clock,
	input issue_pkg::tag_t [2*issue_pkg::N_WAY-1:0] rd_tag,
	output issue_pkg::word_t [2*issue_pkg::N_WAY-1:0] rd_data,
	input logic [issue_pkg::N_WAY-1:0] wr_en,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] wr_tag,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] wr_data,
	input issue_pkg::tag_t zero_reg_pr
);
	import issue_pkg::*;

	word_t regs [N_PHYS_REGS];

	// later port wins on a tag clash
	always_ff @(posedge clock) begin
		for (int p = 0; p < N_WAY; p++) begin
			if (wr_en[p]) begin
				regs[wr_tag[p]] <= wr_data[p];
			end
		end
	end

	always_comb begin
		for (int r = 0; r < 2*N_WAY; r++) begin
			if (rd_tag[r] == zero_reg_pr) begin
				rd_data[r] = '0;
			end else begin
				rd_data[r] = regs[rd_tag[r]];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/issue_select.sv
/*
 * issue selection
 * buffered entries go first by age, then new lanes in lane order,
 * each under the per-class budget; winners packed from lane 0
 */
`timescale 1ns/1ps
`default_nettype none

module issue_select (
	input logic clock,
	input logic reset,
	input logic [issue_pkg::N_WAY-1:0] buf_valid,
	input issue_pkg::lane_count_t [issue_pkg::N_WAY-1:0] buf_age,
	input issue_pkg::unit_e [issue_pkg::N_WAY-1:0] buf_unit,
	input issue_pkg::alu_func_e [issue_pkg::N_WAY-1:0] buf_alu_func,
	input issue_pkg::opa_sel_e [issue_pkg::N_WAY-1:0] buf_opa_select,
	input issue_pkg::opb_sel_e [issue_pkg::N_WAY-1:0] buf_opb_select,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] buf_rs1_value,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] buf_rs2_value,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] buf_dest_tag,
	input issue_pkg::inst_t [issue_pkg::N_WAY-1:0] buf_inst,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] buf_pc,
	input logic [issue_pkg::N_WAY-1:0] new_valid,
	input issue_pkg::unit_e [issue_pkg::N_WAY-1:0] new_unit,
	input issue_pkg::alu_func_e [issue_pkg::N_WAY-1:0] new_alu_func,
	input issue_pkg::opa_sel_e [issue_pkg::N_WAY-1:0] new_opa_select,
	input issue_pkg::opb_sel_e [issue_pkg::N_WAY-1:0] new_opb_select,
	input logic [issue_pkg::N_WAY-1:0] new_has_dest,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] new_rs1_value,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] new_rs2_value,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] new_dest_tag,
	input issue_pkg::inst_t [issue_pkg::N_WAY-1:0] new_inst,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] new_pc,
	output logic [issue_pkg::N_WAY-1:0] take,
	output logic [issue_pkg::N_WAY-1:0] defer,
	output issue_pkg::tag_t [issue_pkg::N_WAY-1:0] defer_dest_tag,
	output logic [issue_pkg::N_WAY-1:0] out_valid,
	output issue_pkg::unit_e [issue_pkg::N_WAY-1:0] out_unit,
	output issue_pkg::alu_func_e [issue_pkg::N_WAY-1:0] out_alu_func,
	output issue_pkg::opa_sel_e [issue_pkg::N_WAY-1:0] out_opa_select,
	output issue_pkg::opb_sel_e [issue_pkg::N_WAY-1:0] out_opb_select,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] out_rs1_value,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] out_rs2_value,
	output issue_pkg::tag_t [issue_pkg::N_WAY-1:0] out_dest_tag,
	output issue_pkg::inst_t [issue_pkg::N_WAY-1:0] out_inst,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] out_pc
);
	import issue_pkg::*;

	// candidates in priority order, buffered by age then new by lane
	logic [2*N_WAY-1:0] c_valid;
	int c_from [N_WAY];
	unit_e [2*N_WAY-1:0] c_unit;
	alu_func_e [2*N_WAY-1:0] c_func;
	opa_sel_e [2*N_WAY-1:0] c_opa;
	opb_sel_e [2*N_WAY-1:0] c_opb;
	word_t [2*N_WAY-1:0] c_rs1;
	word_t [2*N_WAY-1:0] c_rs2;
	tag_t [2*N_WAY-1:0] c_tag;
	inst_t [2*N_WAY-1:0] c_inst;
	word_t [2*N_WAY-1:0] c_pc;
	lane_count_t budget [ALU:BRANCH];
	int n_out;

	///////////////////////////////////////////////////////////////////////
	// candidate list
	always_comb begin
		for (int k = 0; k < N_WAY; k++) begin
			c_from[k] = 0;
			c_valid[k] = 1'b0;
			// ages are compact, so age k+1 lands in slot k
			for (int j = 0; j < N_WAY; j++) begin
				if (buf_valid[j] && int'(buf_age[j]) == k + 1) begin
					c_from[k] = j;
					c_valid[k] = 1'b1;
				end
			end
			c_unit[k] = buf_unit[c_from[k]];
			c_func[k] = buf_alu_func[c_from[k]];
			c_opa[k] = buf_opa_select[c_from[k]];
			c_opb[k] = buf_opb_select[c_from[k]];
			c_rs1[k] = buf_rs1_value[c_from[k]];
			c_rs2[k] = buf_rs2_value[c_from[k]];
			c_tag[k] = buf_dest_tag[c_from[k]];
			c_inst[k] = buf_inst[c_from[k]];
			c_pc[k] = buf_pc[c_from[k]];

			c_valid[N_WAY+k] = new_valid[k];
			c_unit[N_WAY+k] = new_unit[k];
			c_func[N_WAY+k] = new_alu_func[k];
			c_opa[N_WAY+k] = new_opa_select[k];
			c_opb[N_WAY+k] = new_opb_select[k];
			c_rs1[N_WAY+k] = new_rs1_value[k];
			c_rs2[N_WAY+k] = new_rs2_value[k];
			c_tag[N_WAY+k] = new_has_dest[k] ? new_dest_tag[k] : ZERO_TAG;
			c_inst[N_WAY+k] = new_inst[k];
			c_pc[N_WAY+k] = new_pc[k];
			// buffer stores the tag already resolved
			defer_dest_tag[k] = c_tag[N_WAY+k];
		end
	end

	///////////////////////////////////////////////////////////////////////
	// budgeted selection and packing
	always_comb begin
		budget[ALU] = ALU_UNITS;
		budget[MULT] = MULT_UNITS;
		budget[LOAD] = LOAD_UNITS;
		budget[STORE] = STORE_UNITS;
		budget[BRANCH] = BRANCH_UNITS;
		n_out = 0;
		take = '0;
		defer = '0;
		out_valid = '0;
		out_rs1_value = '0;
		out_rs2_value = '0;
		out_dest_tag = '0;
		out_inst = '0;
		out_pc = '0;
		for (int l = 0; l < N_WAY; l++) begin
			out_unit[l] = ALU;
			out_alu_func[l] = ADD;
			out_opa_select[l] = RS1;
			out_opb_select[l] = RS2;
		end
		for (int k = 0; k < 2*N_WAY; k++) begin
			if (c_valid[k] && budget[c_unit[k]] != '0 && n_out < N_WAY) begin
				out_valid[n_out] = 1'b1;
				out_unit[n_out] = c_unit[k];
				out_alu_func[n_out] = c_func[k];
				out_opa_select[n_out] = c_opa[k];
				out_opb_select[n_out] = c_opb[k];
				out_rs1_value[n_out] = c_rs1[k];
				out_rs2_value[n_out] = c_rs2[k];
				out_dest_tag[n_out] = c_tag[k];
				out_inst[n_out] = c_inst[k];
				out_pc[n_out] = c_pc[k];
				budget[c_unit[k]] = budget[c_unit[k]] - 1'b1;
				n_out++;
				if (k < N_WAY) begin
					take[c_from[k]] = 1'b1;
				end
			end else if (c_valid[k] && k >= N_WAY) begin
				// new lane loses, goes to the buffer
				defer[k-N_WAY] = 1'b1;
			end
		end
	end

	// issued lanes form a solid block starting at lane 0
	a_out_packed: assert property (@(posedge clock) disable iff (reset)
		(out_valid & (out_valid + 1'b1)) == '0);

endmodule

`default_nettype wire

// File: logic/hold_buffer.sv
/*
 * hold buffer for instructions that lost selection
 * keeps operands and an age rank per entry, compacts
 * ranks as entries leave and reports the free-slot credit
 */
`timescale 1ns/1ps
`default_nettype none

module hold_buffer (
	input logic clock,
	input logic reset,
	output logic [issue_pkg::N_WAY-1:0] entry_valid,
	output issue_pkg::lane_count_t [issue_pkg::N_WAY-1:0] entry_age,
	output issue_pkg::unit_e [issue_pkg::N_WAY-1:0] entry_unit,
	output issue_pkg::alu_func_e [issue_pkg::N_WAY-1:0] entry_alu_func,
	output issue_pkg::opa_sel_e [issue_pkg::N_WAY-1:0] entry_opa_select,
	output issue_pkg::opb_sel_e [issue_pkg::N_WAY-1:0] entry_opb_select,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] entry_rs1_value,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] entry_rs2_value,
	output issue_pkg::tag_t [issue_pkg::N_WAY-1:0] entry_dest_tag,
	output issue_pkg::inst_t [issue_pkg::N_WAY-1:0] entry_inst,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] entry_pc,
	input logic [issue_pkg::N_WAY-1:0] take,
	input logic [issue_pkg::N_WAY-1:0] defer,
	input issue_pkg::unit_e [issue_pkg::N_WAY-1:0] new_unit,
	input issue_pkg::alu_func_e [issue_pkg::N_WAY-1:0] new_alu_func,
	input issue_pkg::opa_sel_e [issue_pkg::N_WAY-1:0] new_opa_select,
	input issue_pkg::opb_sel_e [issue_pkg::N_WAY-1:0] new_opb_select,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] new_rs1_value,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] new_rs2_value,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] new_dest_tag,
	input issue_pkg::inst_t [issue_pkg::N_WAY-1:0] new_inst,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] new_pc,
	output issue_pkg::lane_count_t free_slots
);
	import issue_pkg::*;

	logic [N_WAY-1:0] keep;
	logic [N_WAY-1:0] nxt_valid;
	lane_count_t [N_WAY-1:0] nxt_age;
	lane_count_t n_next;
	logic [N_WAY-1:0] fill_en;
	int fill_lane [N_WAY];
	logic placed;
	logic lost;
	logic ages_ok;

	///////////////////////////////////////////////////////////////////////
	// next state
	always_comb begin
		keep = entry_valid & ~take;
		n_next = '0;
		// survivors close up, rank = 1 + older survivors
		for (int j = 0; j < N_WAY; j++) begin
			nxt_age[j] = '0;
			if (keep[j]) begin
				n_next = n_next + 1'b1;
				nxt_age[j] = lane_count_t'(1);
				for (int k = 0; k < N_WAY; k++) begin
					if (keep[k] && entry_age[k] < entry_age[j]) begin
						nxt_age[j] = nxt_age[j] + 1'b1;
					end
				end
			end
		end

		// deferred lanes take free entries, younger than all survivors
		nxt_valid = keep;
		fill_en = '0;
		lost = 1'b0;
		for (int j = 0; j < N_WAY; j++) begin
			fill_lane[j] = 0;
		end
		for (int i = 0; i < N_WAY; i++) begin
			placed = 1'b0;
			for (int j = 0; j < N_WAY; j++) begin
				if (defer[i] && !placed && !nxt_valid[j]) begin
					nxt_valid[j] = 1'b1;
					fill_en[j] = 1'b1;
					fill_lane[j] = i;
					n_next = n_next + 1'b1;
					nxt_age[j] = n_next;
					placed = 1'b1;
				end
			end
			if (defer[i] && !placed) begin
				lost = 1'b1;
			end
		end

		// credit for the lanes sampled at the coming edge
		free_slots = lane_count_t'(N_WAY) - n_next;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
			entry_age <= '0;
		end else begin
			entry_valid <= nxt_valid;
			entry_age <= nxt_age;
		end
		for (int j = 0; j < N_WAY; j++) begin
			if (fill_en[j]) begin
				entry_unit[j] <= new_unit[fill_lane[j]];
				entry_alu_func[j] <= new_alu_func[fill_lane[j]];
				entry_opa_select[j] <= new_opa_select[fill_lane[j]];
				entry_opb_select[j] <= new_opb_select[fill_lane[j]];
				entry_rs1_value[j] <= new_rs1_value[fill_lane[j]];
				entry_rs2_value[j] <= new_rs2_value[fill_lane[j]];
				entry_dest_tag[j] <= new_dest_tag[fill_lane[j]];
				entry_inst[j] <= new_inst[fill_lane[j]];
				entry_pc[j] <= new_pc[fill_lane[j]];
			end
		end
	end

	///////////////////////////////////////////////////////////////////////
	// checks
	always_comb begin
		ages_ok = 1'b1;
		for (int j = 0; j < N_WAY; j++) begin
			for (int k = j + 1; k < N_WAY; k++) begin
				if (entry_valid[j] && entry_valid[k] && entry_age[j] == entry_age[k]) begin
					ages_ok = 1'b0;
				end
			end
		end
	end

	// credit upstream must keep deferrals within the free entries
	a_no_overflow: assert property (@(posedge clock) disable iff (reset) !lost);

	a_ages_unique: assert property (@(posedge clock) disable iff (reset) ages_ok);

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
/*
 * issue stage top level
 * input lane register, decoder, physical register file,
 * issue selection and hold buffer
 */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input logic clock,
	input logic reset,
	input logic [issue_pkg::N_WAY-1:0] in_valid,
	input issue_pkg::inst_t [issue_pkg::N_WAY-1:0] in_inst,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] in_pc,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] in_src1_tag,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] in_src2_tag,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] in_dest_tag,
	input logic [issue_pkg::N_WAY-1:0] wb_en,
	input issue_pkg::tag_t [issue_pkg::N_WAY-1:0] wb_tag,
	input issue_pkg::word_t [issue_pkg::N_WAY-1:0] wb_data,
	input issue_pkg::tag_t zero_reg_pr,
	output issue_pkg::lane_count_t free_slots,
	output logic [issue_pkg::N_WAY-1:0] out_valid,
	output issue_pkg::unit_e [issue_pkg::N_WAY-1:0] out_unit,
	output issue_pkg::alu_func_e [issue_pkg::N_WAY-1:0] out_alu_func,
	output issue_pkg::opa_sel_e [issue_pkg::N_WAY-1:0] out_opa_select,
	output issue_pkg::opb_sel_e [issue_pkg::N_WAY-1:0] out_opb_select,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] out_rs1_value,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] out_rs2_value,
	output issue_pkg::tag_t [issue_pkg::N_WAY-1:0] out_dest_tag,
	output issue_pkg::inst_t [issue_pkg::N_WAY-1:0] out_inst,
	output issue_pkg::word_t [issue_pkg::N_WAY-1:0] out_pc
);
	import issue_pkg::*;

	// input lane register
	logic [N_WAY-1:0] lane_valid;
	inst_t [N_WAY-1:0] lane_inst;
	word_t [N_WAY-1:0] lane_pc;
	tag_t [N_WAY-1:0] lane_src1;
	tag_t [N_WAY-1:0] lane_src2;
	tag_t [N_WAY-1:0] lane_dest;

	alu_func_e [N_WAY-1:0] dec_alu_func;
	opa_sel_e [N_WAY-1:0] dec_opa;
	opb_sel_e [N_WAY-1:0] dec_opb;
	logic [N_WAY-1:0] dec_has_dest;
	unit_e [N_WAY-1:0] dec_unit;

	tag_t [2*N_WAY-1:0] rd_tag;
	word_t [2*N_WAY-1:0] rd_data;
	word_t [N_WAY-1:0] new_rs1;
	word_t [N_WAY-1:0] new_rs2;

	logic [N_WAY-1:0] buf_valid;
	lane_count_t [N_WAY-1:0] buf_age;
	unit_e [N_WAY-1:0] buf_unit;
	alu_func_e [N_WAY-1:0] buf_alu_func;
	opa_sel_e [N_WAY-1:0] buf_opa;
	opb_sel_e [N_WAY-1:0] buf_opb;
	word_t [N_WAY-1:0] buf_rs1;
	word_t [N_WAY-1:0] buf_rs2;
	tag_t [N_WAY-1:0] buf_tag;
	inst_t [N_WAY-1:0] buf_inst;
	word_t [N_WAY-1:0] buf_pc;
	logic [N_WAY-1:0] take;
	logic [N_WAY-1:0] defer;
	tag_t [N_WAY-1:0] defer_dest_tag;

	always_ff @(posedge clock) begin
		if (reset) begin
			lane_valid <= '0;
			lane_inst <= '0;
			lane_pc <= '0;
			lane_src1 <= '0;
			lane_src2 <= '0;
			lane_dest <= '0;
		end else begin
			lane_valid <= in_valid;
			lane_inst <= in_inst;
			lane_pc <= in_pc;
			lane_src1 <= in_src1_tag;
			lane_src2 <= in_src2_tag;
			lane_dest <= in_dest_tag;
		end
	end

	// read ports 2i and 2i+1 serve lane i
	always_comb begin
		for (int i = 0; i < N_WAY; i++) begin
			rd_tag[2*i] = lane_src1[i];
			rd_tag[2*i+1] = lane_src2[i];
			new_rs1[i] = rd_data[2*i];
			new_rs2[i] = rd_data[2*i+1];
		end
	end

	issue_decoder i_decoder (
		.inst(lane_inst), .lane_valid(lane_valid), .alu_func(dec_alu_func),
		.opa_select(dec_opa), .opb_select(dec_opb), .has_dest(dec_has_dest),
		.unit(dec_unit)
	);

	phys_regfile i_regfile (
		.clock(clock), .rd_tag(rd_tag), .rd_data(rd_data), .wr_en(wb_en),
		.wr_tag(wb_tag), .wr_data(wb_data), .zero_reg_pr(zero_reg_pr)
	);

	issue_select i_select (
		.clock(clock), .reset(reset),
		.buf_valid(buf_valid), .buf_age(buf_age), .buf_unit(buf_unit),
		.buf_alu_func(buf_alu_func), .buf_opa_select(buf_opa), .buf_opb_select(buf_opb),
		.buf_rs1_value(buf_rs1), .buf_rs2_value(buf_rs2), .buf_dest_tag(buf_tag),
		.buf_inst(buf_inst), .buf_pc(buf_pc),
		.new_valid(lane_valid), .new_unit(dec_unit), .new_alu_func(dec_alu_func),
		.new_opa_select(dec_opa), .new_opb_select(dec_opb), .new_has_dest(dec_has_dest),
		.new_rs1_value(new_rs1), .new_rs2_value(new_rs2), .new_dest_tag(lane_dest),
		.new_inst(lane_inst), .new_pc(lane_pc),
		.take(take), .defer(defer), .defer_dest_tag(defer_dest_tag),
		.out_valid(out_valid), .out_unit(out_unit), .out_alu_func(out_alu_func),
		.out_opa_select(out_opa_select), .out_opb_select(out_opb_select),
		.out_rs1_value(out_rs1_value), .out_rs2_value(out_rs2_value),
		.out_dest_tag(out_dest_tag), .out_inst(out_inst), .out_pc(out_pc)
	);

	hold_buffer i_hold (
		.clock(clock), .reset(reset),
		.entry_valid(buf_valid), .entry_age(buf_age), .entry_unit(buf_unit),
		.entry_alu_func(buf_alu_func), .entry_opa_select(buf_opa),
		.entry_opb_select(buf_opb), .entry_rs1_value(buf_rs1), .entry_rs2_value(buf_rs2),
		.entry_dest_tag(buf_tag), .entry_inst(buf_inst), .entry_pc(buf_pc),
		.take(take), .defer(defer),
		.new_unit(dec_unit), .new_alu_func(dec_alu_func), .new_opa_select(dec_opa),
		.new_opb_select(dec_opb), .new_rs1_value(new_rs1), .new_rs2_value(new_rs2),
		.new_dest_tag(defer_dest_tag), .new_inst(lane_inst), .new_pc(lane_pc),
		.free_slots(free_slots)
	);

endmodule

`default_nettype wire

// File: dv/issue_stage_tb.sv
/*
 * testbench for the two-wide issue stage
 * clock and reset, a table of lane stimulus with expected outputs,
 * a register file model fed from an LFSR, checks and summary
 */
`timescale 1ns/1ps
`default_nettype none

module issue_stage_tb;
	import issue_pkg::*;

	localparam tag_t ZERO_PR = 6'd33;
	localparam int TIMEOUT_CYCLES = 20;

	// one cycle of stimulus and the outputs expected in the following cycle
	typedef struct packed {
		logic [N_WAY-1:0] in_valid;
		inst_t [N_WAY-1:0] in_inst;
		word_t [N_WAY-1:0] in_pc;
		tag_t [N_WAY-1:0] in_src1;
		tag_t [N_WAY-1:0] in_src2;
		tag_t [N_WAY-1:0] in_dest;
		logic [N_WAY-1:0] wb_en;
		tag_t [N_WAY-1:0] wb_tag;
		word_t [N_WAY-1:0] wb_data;
		logic [N_WAY-1:0] exp_valid;
		unit_e [N_WAY-1:0] exp_unit;
		alu_func_e [N_WAY-1:0] exp_func;
		opa_sel_e [N_WAY-1:0] exp_opa;
		opb_sel_e [N_WAY-1:0] exp_opb;
		word_t [N_WAY-1:0] exp_rs1;
		word_t [N_WAY-1:0] exp_rs2;
		tag_t [N_WAY-1:0] exp_dest;
		inst_t [N_WAY-1:0] exp_inst;
		word_t [N_WAY-1:0] exp_pc;
		lane_count_t exp_free;
	} row_t;

	logic clock;
	logic reset;
	logic [N_WAY-1:0] in_valid;
	inst_t [N_WAY-1:0] in_inst;
	word_t [N_WAY-1:0] in_pc;
	tag_t [N_WAY-1:0] in_src1_tag;
	tag_t [N_WAY-1:0] in_src2_tag;
	tag_t [N_WAY-1:0] in_dest_tag;
	logic [N_WAY-1:0] wb_en;
	tag_t [N_WAY-1:0] wb_tag;
	word_t [N_WAY-1:0] wb_data;
	tag_t zero_reg_pr;
	lane_count_t free_slots;
	logic [N_WAY-1:0] out_valid;
	unit_e [N_WAY-1:0] out_unit;
	alu_func_e [N_WAY-1:0] out_alu_func;
	opa_sel_e [N_WAY-1:0] out_opa_select;
	opb_sel_e [N_WAY-1:0] out_opb_select;
	word_t [N_WAY-1:0] out_rs1_value;
	word_t [N_WAY-1:0] out_rs2_value;
	tag_t [N_WAY-1:0] out_dest_tag;
	inst_t [N_WAY-1:0] out_inst;
	word_t [N_WAY-1:0] out_pc;

	row_t rows [$];
	row_t cur;
	word_t reg_model [N_PHYS_REGS];
	logic [31:0] lfsr;
	int errors;
	int timeouts;
	int checks;

	issue_stage i_dut (
		.clock(clock), .reset(reset), .in_valid(in_valid), .in_inst(in_inst),
		.in_pc(in_pc), .in_src1_tag(in_src1_tag), .in_src2_tag(in_src2_tag),
		.in_dest_tag(in_dest_tag), .wb_en(wb_en), .wb_tag(wb_tag), .wb_data(wb_data),
		.zero_reg_pr(zero_reg_pr), .free_slots(free_slots), .out_valid(out_valid),
		.out_unit(out_unit), .out_alu_func(out_alu_func),
		.out_opa_select(out_opa_select), .out_opb_select(out_opb_select),
		.out_rs1_value(out_rs1_value), .out_rs2_value(out_rs2_value),
		.out_dest_tag(out_dest_tag), .out_inst(out_inst), .out_pc(out_pc)
	);

	initial begin
		clock = 1'b0;
	end

	always #5 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers

	// right-shifting Galois step
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			lfsr_step = (state >> 1) ^ 32'hD000_0001;
		end else begin
			lfsr_step = state >> 1;
		end
	endfunction

	task automatic next_word(output word_t w);
		w = '0;
		for (int b = 0; b < XLEN; b++) begin
			w = {w[XLEN-2:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// rs2 = 2, rs1 = 1, rd = 3 in every word
	function automatic inst_t encode(input logic [6:0] funct7, input logic [2:0] funct3,
		input logic [6:0] opcode);
		encode = {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};
	endfunction

	function automatic word_t read_model(input tag_t tag);
		if (tag == ZERO_PR) begin
			read_model = '0;
		end else begin
			read_model = reg_model[tag];
		end
	endfunction

	task automatic start_row(input int free);
		cur = '0;
		cur.exp_free = lane_count_t'(free);
	endtask

	// visible to lanes of the same row, later port wins
	task automatic write_back(input int port, input tag_t tag);
		word_t w;
		next_word(w);
		cur.wb_en[port] = 1'b1;
		cur.wb_tag[port] = tag;
		cur.wb_data[port] = w;
		reg_model[tag] = w;
	endtask

	task automatic drive_lane(input int l, input inst_t inst, input tag_t s1, input tag_t s2,
		input tag_t d);
		cur.in_valid[l] = 1'b1;
		cur.in_inst[l] = inst;
		cur.in_pc[l] = word_t'(32'h1000 + rows.size() * 8 + l * 4);
		cur.in_src1[l] = s1;
		cur.in_src2[l] = s2;
		cur.in_dest[l] = d;
	endtask

	task automatic expect_lane(input int o, input inst_t inst, input word_t pc,
		input word_t rs1, input word_t rs2, input tag_t dest, input unit_e u,
		input alu_func_e f, input opa_sel_e a, input opb_sel_e b);
		cur.exp_valid[o] = 1'b1;
		cur.exp_inst[o] = inst;
		cur.exp_pc[o] = pc;
		cur.exp_rs1[o] = rs1;
		cur.exp_rs2[o] = rs2;
		cur.exp_dest[o] = dest;
		cur.exp_unit[o] = u;
		cur.exp_func[o] = f;
		cur.exp_opa[o] = a;
		cur.exp_opb[o] = b;
	endtask

	// lane l issues in the next cycle on out lane o
	task automatic issue_now(input int l, input int o, input inst_t inst, input tag_t s1,
		input tag_t s2, input tag_t d, input tag_t dest_exp, input unit_e u,
		input alu_func_e f, input opa_sel_e a, input opb_sel_e b);
		drive_lane(l, inst, s1, s2, d);
		expect_lane(o, inst, cur.in_pc[l], read_model(s1), read_model(s2), dest_exp,
			u, f, a, b);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	task automatic build_table();
		word_t held_rs1;
		word_t held_rs2;
		inst_t held_inst;
		word_t held_pc;

		// same-edge writeback reads, x0 register reads zero
		start_row(2);
		write_back(0, 6'd1);
		write_back(1, 6'd2);
		issue_now(0, 0, encode(7'h00, 3'b000, OP_REG), 6'd1, 6'd2, 6'd10, 6'd10,
			ALU, ADD, RS1, RS2);
		issue_now(1, 1, encode(7'h00, 3'b000, OP_REG), ZERO_PR, 6'd2, 6'd11, 6'd11,
			ALU, ADD, RS1, RS2);
		rows.push_back(cur);

		start_row(2);
		write_back(0, 6'd3);
		write_back(1, ZERO_PR);
		issue_now(0, 0, encode(7'h00, 3'b000, OP_LUI), ZERO_PR, 6'd3, 6'd12, 6'd12,
			ALU, ADD, ZERO, U_IMM);
		issue_now(1, 1, encode(7'h00, 3'b000, OP_AUIPC), 6'd3, 6'd1, 6'd13, 6'd13,
			ALU, ADD, PC, U_IMM);
		rows.push_back(cur);

		// both ports on one tag
		start_row(2);
		write_back(0, 6'd4);
		write_back(1, 6'd4);
		issue_now(0, 0, encode(7'h00, 3'b000, OP_JAL), 6'd4, 6'd1, 6'd14, 6'd14,
			ALU, ADD, PC, J_IMM);
		issue_now(1, 1, encode(7'h00, 3'b000, OP_JALR), 6'd4, 6'd2, 6'd15, 6'd15,
			ALU, ADD, RS1, I_IMM);
		rows.push_back(cur);

		start_row(2);
		issue_now(0, 0, encode(7'h00, 3'b000, OP_BRANCH), 6'd1, 6'd2, 6'd16, ZERO_TAG,
			BRANCH, ADD, PC, B_IMM);
		issue_now(1, 1, encode(7'h00, 3'b010, OP_LOAD), 6'd3, ZERO_PR, 6'd17, 6'd17,
			LOAD, ADD, RS1, I_IMM);
		rows.push_back(cur);

		start_row(2);
		issue_now(0, 0, encode(7'h00, 3'b010, OP_STORE), 6'd2, 6'd4, 6'd18, ZERO_TAG,
			STORE, ADD, RS1, S_IMM);
		issue_now(1, 1, encode(7'h00, 3'b000, OP_IMM), 6'd1, ZERO_PR, 6'd19, 6'd19,
			ALU, ADD, RS1, I_IMM);
		rows.push_back(cur);

		start_row(2);
		issue_now(0, 0, encode(7'b0100000, 3'b000, OP_REG), 6'd3, 6'd1, 6'd20, 6'd20,
			ALU, SUB, RS1, RS2);
		issue_now(1, 1, encode(7'h00, 3'b011, OP_REG), 6'd4, 6'd2, 6'd21, 6'd21,
			ALU, SLTU, RS1, RS2);
		rows.push_back(cur);

		start_row(2);
		write_back(0, 6'd1);
		write_back(1, 6'd2);
		issue_now(0, 0, encode(FUNCT7_MULDIV, 3'b000, OP_REG), 6'd1, 6'd2, 6'd22, 6'd22,
			MULT, MUL, RS1, RS2);
		rows.push_back(cur);

		// two loads, the second one waits in the buffer
		start_row(1);
		write_back(0, 6'd3);
		issue_now(0, 0, encode(7'h00, 3'b010, OP_LOAD), 6'd1, 6'd2, 6'd23, 6'd23,
			LOAD, ADD, RS1, I_IMM);
		drive_lane(1, encode(7'h00, 3'b010, OP_LOAD), 6'd3, 6'd4, 6'd24);
		held_rs1 = read_model(6'd3);
		held_rs2 = read_model(6'd4);
		held_inst = cur.in_inst[1];
		held_pc = cur.in_pc[1];
		rows.push_back(cur);

		// new data at the held load's tags must not reach it
		start_row(2);
		expect_lane(0, held_inst, held_pc, held_rs1, held_rs2, 6'd24, LOAD, ADD, RS1, I_IMM);
		write_back(0, 6'd3);
		write_back(1, 6'd4);
		issue_now(0, 1, encode(7'h00, 3'b000, OP_REG), 6'd3, 6'd4, 6'd25, 6'd25,
			ALU, ADD, RS1, RS2);
		rows.push_back(cur);

		start_row(1);
		issue_now(0, 0, encode(FUNCT7_MULDIV, 3'b000, OP_REG), 6'd1, 6'd2, 6'd26, 6'd26,
			MULT, MUL, RS1, RS2);
		drive_lane(1, encode(FUNCT7_MULDIV, 3'b011, OP_REG), 6'd3, 6'd4, 6'd27);
		held_rs1 = read_model(6'd3);
		held_rs2 = read_model(6'd4);
		held_inst = cur.in_inst[1];
		held_pc = cur.in_pc[1];
		rows.push_back(cur);

		// buffered multiply beats the new one, store packs into out lane 1
		start_row(1);
		expect_lane(0, held_inst, held_pc, held_rs1, held_rs2, 6'd27, MULT, MULHU, RS1, RS2);
		write_back(0, 6'd1);
		drive_lane(0, encode(FUNCT7_MULDIV, 3'b001, OP_REG), 6'd1, 6'd3, 6'd28);
		held_rs1 = read_model(6'd1);
		held_rs2 = read_model(6'd3);
		held_inst = cur.in_inst[0];
		held_pc = cur.in_pc[0];
		issue_now(1, 1, encode(7'h00, 3'b010, OP_STORE), 6'd2, 6'd4, 6'd40, ZERO_TAG,
			STORE, ADD, RS1, S_IMM);
		rows.push_back(cur);

		start_row(2);
		expect_lane(0, held_inst, held_pc, held_rs1, held_rs2, 6'd28, MULT, MULH, RS1, RS2);
		rows.push_back(cur);

		// load and store together
		start_row(2);
		issue_now(0, 0, encode(7'h00, 3'b010, OP_LOAD), 6'd1, 6'd3, 6'd29, 6'd29,
			LOAD, ADD, RS1, I_IMM);
		issue_now(1, 1, encode(7'h00, 3'b010, OP_STORE), 6'd2, ZERO_PR, 6'd30, ZERO_TAG,
			STORE, ADD, RS1, S_IMM);
		rows.push_back(cur);

		start_row(2);
		rows.push_back(cur);
	endtask

	task automatic apply_inputs(input row_t row);
		in_valid = row.in_valid;
		in_inst = row.in_inst;
		in_pc = row.in_pc;
		in_src1_tag = row.in_src1;
		in_src2_tag = row.in_src2;
		in_dest_tag = row.in_dest;
		wb_en = row.wb_en;
		wb_tag = row.wb_tag;
		wb_data = row.wb_data;
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	task automatic check_value(input string name, input int r, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: row %0d %s = %h, expected %h", r, name, got, exp);
		end
	endtask

	task automatic check_row(input int r, input row_t row);
		check_value("free_slots", r, free_slots, row.exp_free);
		check_value("out_valid", r, out_valid, row.exp_valid);
		for (int o = 0; o < N_WAY; o++) begin
			check_value($sformatf("out_unit[%0d]", o), r, out_unit[o], row.exp_unit[o]);
			check_value($sformatf("out_alu_func[%0d]", o), r, out_alu_func[o],
				row.exp_func[o]);
			check_value($sformatf("out_opa_select[%0d]", o), r, out_opa_select[o],
				row.exp_opa[o]);
			check_value($sformatf("out_opb_select[%0d]", o), r, out_opb_select[o],
				row.exp_opb[o]);
			check_value($sformatf("out_rs1_value[%0d]", o), r, out_rs1_value[o],
				row.exp_rs1[o]);
			check_value($sformatf("out_rs2_value[%0d]", o), r, out_rs2_value[o],
				row.exp_rs2[o]);
			check_value($sformatf("out_dest_tag[%0d]", o), r, out_dest_tag[o],
				row.exp_dest[o]);
			check_value($sformatf("out_inst[%0d]", o), r, out_inst[o], row.exp_inst[o]);
			check_value($sformatf("out_pc[%0d]", o), r, out_pc[o], row.exp_pc[o]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		row_t idle_row;
		int wait_cycles;

		idle_row = '0;
		errors = 0;
		timeouts = 0;
		checks = 0;
		lfsr = 32'd29511;
		reset = 1'b1;
		zero_reg_pr = ZERO_PR;
		apply_inputs(idle_row);
		build_table();

		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;

		// idle outputs and a full credit right after reset
		#8;
		checks += 2;
		if (out_valid !== '0) begin
			errors++;
			$display("error: after reset out_valid = %h, expected %h", out_valid, 2'h0);
		end
		if (free_slots !== lane_count_t'(N_WAY)) begin
			errors++;
			$display("error: after reset free_slots = %h, expected %h", free_slots,
				lane_count_t'(N_WAY));
		end

		// inputs of row r go in while the outputs of row r-1 are checked
		for (int r = 0; r <= rows.size(); r++) begin
			@(posedge clock);
			#1;
			if (r < rows.size()) begin
				apply_inputs(rows[r]);
			end else begin
				apply_inputs(idle_row);
			end
			#8;
			if (r > 0) begin
				check_row(r - 1, rows[r-1]);
			end
		end

		// buffer drains to a full credit
		wait_cycles = 0;
		while (free_slots !== lane_count_t'(N_WAY) && wait_cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			#9;
			wait_cycles++;
		end
		if (wait_cycles == TIMEOUT_CYCLES) begin
			timeouts++;
			$display("timeout: the hold buffer did not drain");
		end

		$display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
logic/issue_pkg.sv
logic/issue_decoder.sv
logic/phys_regfile.sv
logic/issue_select.sv
logic/hold_buffer.sv
logic/issue_stage.sv
dv/issue_stage_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = issue_stage_tb
FILELIST = project.f
OBJ_DIR = obj_dir
PASS_MSG = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
